/* ddr_cfg.svh */
// ddr front end parameters
`ifndef DDR_CFG_SVH
`define DDR_CFG_SVH

// --------------------
// widths
// --------------------
`define RAM_AW 30     // cpu word address
`define APP_AW 27     // app interface address
`define APP_DW 128    // app interface data, half a block

// --------------------
// memory model
// --------------------
`define MEM_AW 8      // log2 of model entries
`define RD_LAT 3      // accept to read valid
`define CALIB_CYC 20  // cycles from reset to calib done

`endif

/* ddr_pkg.sv */
// ddr front end types
package ddr_pkg;

`include "ddr_cfg.svh"

    // block split in two app-width halves, hi is bits 255:128
    typedef struct packed {
        logic [`APP_DW-1:0] hi;
        logic [`APP_DW-1:0] lo;
    } block_halves_t;

    // same 256 bits, read whole or by halves
    typedef union packed {
        logic [2*`APP_DW-1:0] flat;
        block_halves_t        half;
    } block_t;

    // app_cmd encodings of the controller ui
    typedef enum logic [2:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } app_cmd_t;

    // last completed op per port
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_NOP   = 2'b11  // nothing done since reset
    } last_op_t;

endpackage

/* ddr_port_ctrl.sv */
// cpu port front end
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module ddr_port_ctrl (
    input  logic                    ui_clk,
    input  logic                    rst,          // sync, active low
    input  logic                    ram_en,
    input  logic                    ram_write,
    input  logic [`RAM_AW-1:0]      ram_addr,     // word address
    input  logic [2*`APP_DW-1:0]    data_to_ram,
    input  logic                    done,         // one-cycle pulse from arbiter
    input  logic [`APP_DW-1:0]      rsp_data,     // valid with done on reads
    output logic                    ram_rdy,
    output ddr_pkg::block_t         block_out,
    output logic                    req,
    output logic                    req_write,
    output logic [`APP_AW-1:0]      req_addr,
    output logic [`APP_DW-1:0]      req_wdata
);

    logic                   reading;
    logic                   writing;
    logic [`RAM_AW-1:0]     last_addr;
    ddr_pkg::last_op_t      last_op;
    ddr_pkg::last_op_t      cur_op;
    ddr_pkg::block_t        buf_q;      // block buffer
    ddr_pkg::block_t        wr_blk;     // incoming block, halves view
    logic                   new_req;
    logic                   sel_hi;

    // --------------------
    // request decode
    // --------------------
    assign cur_op  = ram_write ? ddr_pkg::OP_WRITE : ddr_pkg::OP_READ;
    assign new_req = ram_en && ((ram_addr != last_addr) || (cur_op != last_op));
    assign sel_hi  = ram_addr[4];   // half select
    assign wr_blk  = data_to_ram;

    assign req       = reading || writing;
    assign req_write = writing;
    assign req_addr  = {ram_addr[`APP_AW-3:0], 2'b00};  // upper word bits dropped
    assign req_wdata = sel_hi ? wr_blk.half.hi : wr_blk.half.lo;

    // repeat of last op, or idle, answers at once
    assign ram_rdy = !new_req && !reading && !writing;

    // --------------------
    // transaction state
    // --------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            reading   <= 1'b0;
            writing   <= 1'b0;
            last_addr <= '1;              // matches no real request
            last_op   <= ddr_pkg::OP_NOP;
        end else if (reading || writing) begin
            if (done) begin
                reading   <= 1'b0;
                writing   <= 1'b0;
                last_addr <= ram_addr;    // peer still holds it
                last_op   <= cur_op;
            end
        end else if (new_req) begin
            writing <= ram_write;
            reading <= !ram_write;
        end
    end

    // read data lands in the addressed half
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            buf_q <= '0;
        end else if (reading && done) begin
            if (sel_hi)
                buf_q.half.hi <= rsp_data;
            else
                buf_q.half.lo <= rsp_data;
        end
    end

    assign block_out = buf_q;

    // --------------------
    // checks
    // --------------------
    // open request held with same address and kind until arbiter answers
    req_hold_a: assert property (@(posedge ui_clk) disable iff (!rst)
        req && !done |=> req && $stable(req_addr) && $stable(req_write));

endmodule

/* app_arbiter.sv */
// two port app interface arbiter
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module app_arbiter (
    input  logic                ui_clk,
    input  logic                rst,
    input  logic                req0,
    input  logic                req1,
    input  logic                req_write0,
    input  logic                req_write1,
    input  logic [`APP_AW-1:0]  req_addr0,
    input  logic [`APP_AW-1:0]  req_addr1,
    input  logic [`APP_DW-1:0]  req_wdata0,
    input  logic [`APP_DW-1:0]  req_wdata1,
    input  logic                app_rdy,
    input  logic                app_wdf_rdy,
    input  logic                init_calib_complete,
    input  logic [`APP_DW-1:0]  app_rd_data,
    input  logic                app_rd_data_valid,
    output logic                done0,
    output logic                done1,
    output logic [`APP_DW-1:0]  rsp_data,
    output logic                app_en,
    output ddr_pkg::app_cmd_t   app_cmd,
    output logic [`APP_AW-1:0]  app_addr,
    output logic [`APP_DW-1:0]  app_wdf_data,
    output logic                app_wdf_wren
);

    logic   granted;    // a port owns the interface
    logic   gnt_sel;    // 0 = fetch port, 1 = load/store port
    logic   last_win;
    logic   rd_pend;    // read accepted, data not back yet
    logic   pick;
    logic   sel_write;
    logic   accept;
    logic   done_p;

    // lower priority to last winner when both ask
    assign pick = (req0 && req1) ? !last_win : req1;

    assign sel_write    = gnt_sel ? req_write1 : req_write0;
    assign app_addr     = gnt_sel ? req_addr1  : req_addr0;
    assign app_wdf_data = gnt_sel ? req_wdata1 : req_wdata0;
    assign app_cmd      = sel_write ? ddr_pkg::CMD_WRITE : ddr_pkg::CMD_READ;

    assign app_en       = granted && !rd_pend;     // held through stalls
    assign app_wdf_wren = app_en && sel_write;
    assign accept       = app_en && app_rdy && app_wdf_rdy && init_calib_complete;

    // write ends on accept, read on returned data
    assign done_p   = (accept && sel_write) || (rd_pend && app_rd_data_valid);
    assign done0    = done_p && !gnt_sel;
    assign done1    = done_p && gnt_sel;
    assign rsp_data = app_rd_data;

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            granted  <= 1'b0;
            gnt_sel  <= 1'b0;
            last_win <= 1'b1;   // port 0 first
            rd_pend  <= 1'b0;
        end else if (!granted) begin
            if (init_calib_complete && (req0 || req1)) begin
                granted <= 1'b1;
                gnt_sel <= pick;
            end
        end else if (done_p) begin
            granted  <= 1'b0;
            last_win <= gnt_sel;
            rd_pend  <= 1'b0;
        end else if (accept && !sel_write) begin
            rd_pend <= 1'b1;
        end
    end

    // --------------------
    // checks
    // --------------------
    // completion only goes back to a port still asking for it
    done_owner_a: assert property (@(posedge ui_clk) disable iff (!rst)
        !(done0 && !req0) && !(done1 && !req1));
    // model never sees a command before calibration
    en_calib_a: assert property (@(posedge ui_clk) disable iff (!rst)
        app_en |-> init_calib_complete);

endmodule

/* app_mem_model.sv */
// behavioural ddr app interface model
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module app_mem_model (
    input  logic                ui_clk,
    input  logic                rst,
    input  logic                app_en,
    input  ddr_pkg::app_cmd_t   app_cmd,
    input  logic [`APP_AW-1:0]  app_addr,
    input  logic [`APP_DW-1:0]  app_wdf_data,
    input  logic                app_wdf_wren,
    output logic                app_rdy,
    output logic                app_wdf_rdy,
    output logic                init_calib_complete,
    output logic [`APP_DW-1:0]  app_rd_data,
    output logic                app_rd_data_valid
);

    localparam int CW = $clog2(`CALIB_CYC + 1);

    logic [`APP_DW-1:0]     mem [2**`MEM_AW];
    logic [CW-1:0]          cal_cnt;
    logic [1:0]             stall_cnt;
    logic [`MEM_AW-1:0]     idx;
    logic                   accept;
    logic                   wr_go;
    logic                   rd_go;
    logic [`RD_LAT-1:0]     rd_vld;                 // valid shift line
    logic [`APP_DW-1:0]     rd_dat [`RD_LAT];

    assign idx    = app_addr[`MEM_AW+1:2];         // low word-address bits
    assign accept = app_en && app_rdy && app_wdf_rdy && init_calib_complete;
    assign wr_go  = accept && (app_cmd == ddr_pkg::CMD_WRITE) && app_wdf_wren;
    assign rd_go  = accept && (app_cmd == ddr_pkg::CMD_READ);

    // --------------------
    // calibration and stalls
    // --------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            cal_cnt             <= '0;
            init_calib_complete <= 1'b0;
        end else if (!init_calib_complete) begin
            cal_cnt <= cal_cnt + 1'b1;
            if (cal_cnt == CW'(`CALIB_CYC - 1))
                init_calib_complete <= 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst)
            stall_cnt <= '0;
        else
            stall_cnt <= stall_cnt + 1'b1;
    end

    assign app_rdy     = (stall_cnt != 2'd3);   // one busy cycle in four
    assign app_wdf_rdy = app_rdy;

    // --------------------
    // storage and read pipe
    // --------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**`MEM_AW; i++)
                mem[i] <= '0;
        end else if (wr_go) begin
            mem[idx] <= app_wdf_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst)
            rd_vld <= '0;
        else
            rd_vld <= {rd_vld[`RD_LAT-2:0], rd_go};
    end

    always_ff @(posedge ui_clk) begin
        rd_dat[0] <= mem[idx];                     // only qualified by rd_vld
        for (int i = 1; i < `RD_LAT; i++)
            rd_dat[i] <= rd_dat[i-1];
    end

    assign app_rd_data       = rd_dat[`RD_LAT-1];
    assign app_rd_data_valid = rd_vld[`RD_LAT-1];

    // write data must come with every write command
    wr_strobe_a: assert property (@(posedge ui_clk) disable iff (!rst)
        app_en && (app_cmd == ddr_pkg::CMD_WRITE) |-> app_wdf_wren);

endmodule

/* ddr_subsys_top.sv */
// shared ddr front end top
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module ddr_subsys_top (
    input  logic                    ui_clk,
    input  logic                    rst,
    // port 0, instruction fetch
    input  logic                    p0_ram_en,
    input  logic                    p0_ram_write,
    input  logic [`RAM_AW-1:0]      p0_ram_addr,
    input  logic [2*`APP_DW-1:0]    p0_data_to_ram,
    output logic                    p0_ram_rdy,
    output ddr_pkg::block_t         p0_block_out,
    // port 1, load/store
    input  logic                    p1_ram_en,
    input  logic                    p1_ram_write,
    input  logic [`RAM_AW-1:0]      p1_ram_addr,
    input  logic [2*`APP_DW-1:0]    p1_data_to_ram,
    output logic                    p1_ram_rdy,
    output ddr_pkg::block_t         p1_block_out
);

    logic                   req0, req1, req_write0, req_write1;
    logic [`APP_AW-1:0]     req_addr0, req_addr1;
    logic [`APP_DW-1:0]     req_wdata0, req_wdata1;
    logic                   done0, done1;
    logic [`APP_DW-1:0]     rsp_data;
    logic                   app_en, app_wdf_wren, app_rdy, app_wdf_rdy;
    logic                   init_calib_complete, app_rd_data_valid;
    ddr_pkg::app_cmd_t      app_cmd;
    logic [`APP_AW-1:0]     app_addr;
    logic [`APP_DW-1:0]     app_wdf_data, app_rd_data;

    ddr_port_ctrl u_port0 (
        .ui_clk(ui_clk), .rst(rst),
        .ram_en(p0_ram_en), .ram_write(p0_ram_write), .ram_addr(p0_ram_addr),
        .data_to_ram(p0_data_to_ram), .done(done0), .rsp_data(rsp_data),
        .ram_rdy(p0_ram_rdy), .block_out(p0_block_out), .req(req0),
        .req_write(req_write0), .req_addr(req_addr0), .req_wdata(req_wdata0)
    );

    ddr_port_ctrl u_port1 (
        .ui_clk(ui_clk), .rst(rst),
        .ram_en(p1_ram_en), .ram_write(p1_ram_write), .ram_addr(p1_ram_addr),
        .data_to_ram(p1_data_to_ram), .done(done1), .rsp_data(rsp_data),
        .ram_rdy(p1_ram_rdy), .block_out(p1_block_out), .req(req1),
        .req_write(req_write1), .req_addr(req_addr1), .req_wdata(req_wdata1)
    );

    app_arbiter u_arb (
        .ui_clk(ui_clk), .rst(rst),
        .req0(req0), .req1(req1), .req_write0(req_write0), .req_write1(req_write1),
        .req_addr0(req_addr0), .req_addr1(req_addr1),
        .req_wdata0(req_wdata0), .req_wdata1(req_wdata1),
        .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
        .init_calib_complete(init_calib_complete),
        .app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid),
        .done0(done0), .done1(done1), .rsp_data(rsp_data),
        .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
        .app_wdf_data(app_wdf_data), .app_wdf_wren(app_wdf_wren)
    );

    app_mem_model u_mem (
        .ui_clk(ui_clk), .rst(rst),
        .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
        .app_wdf_data(app_wdf_data), .app_wdf_wren(app_wdf_wren),
        .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
        .init_calib_complete(init_calib_complete),
        .app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid)
    );

endmodule

/* tb_checker.sv */
// ddr front end checker
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module tb_checker (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic                    p0_ram_en,
    input  logic                    p0_ram_write,
    input  logic [`RAM_AW-1:0]      p0_ram_addr,
    input  logic [2*`APP_DW-1:0]    p0_data_to_ram,
    input  logic                    p0_ram_rdy,
    input  ddr_pkg::block_t         p0_block_out,
    input  logic                    p1_ram_en,
    input  logic                    p1_ram_write,
    input  logic [`RAM_AW-1:0]      p1_ram_addr,
    input  logic [2*`APP_DW-1:0]    p1_data_to_ram,
    input  logic                    p1_ram_rdy,
    input  ddr_pkg::block_t         p1_block_out,
    input  logic [127:0]            name0,          // case names, ascii
    input  logic [127:0]            name1,
    input  ddr_pkg::block_t         exp0,           // block from the case file
    input  ddr_pkg::block_t         exp1,
    output int                      errors
);

    logic [`APP_DW-1:0]     shadow_mem [2**`MEM_AW];   // keyed by low word-address bits
    ddr_pkg::block_t        shadow_blk [2];
    logic [`RAM_AW-1:0]     last_addr [2];
    ddr_pkg::last_op_t      last_op [2];
    logic                   reset_checked;

    // model value first, then the case file
    task automatic compare_half(input logic [127:0] name, input string which,
            input logic [`APP_DW-1:0] model_val, input logic [`APP_DW-1:0] file_val,
            input logic [`APP_DW-1:0] act);
        if (act !== model_val) begin
            $display("[ERROR] %0s %s half expected %h actual %h", name, which, model_val, act);
            errors++;
        end else if (act !== file_val) begin
            $display("[ERROR] %0s %s half expected %h (case file) actual %h",
                name, which, file_val, act);
            errors++;
        end
    endtask

    // --------------------
    // per-port tracking
    // --------------------
    task automatic step_port(input int p, input logic en, input logic wr,
            input logic [`RAM_AW-1:0] addr, input ddr_pkg::block_t wblk, input logic rdy,
            input ddr_pkg::block_t blk, input logic [127:0] name,
            input ddr_pkg::block_t file_blk);
        ddr_pkg::last_op_t  op;
        ddr_pkg::block_t    cur;
        logic [`MEM_AW-1:0] key;
        logic               fresh;
        op    = wr ? ddr_pkg::OP_WRITE : ddr_pkg::OP_READ;
        key   = addr[`MEM_AW-1:0];
        fresh = (addr != last_addr[p]) || (op != last_op[p]);
        cur   = shadow_blk[p];
        if (en && fresh && rdy) begin
            // rdy on a new request means it just completed
            last_addr[p] = addr;
            last_op[p]   = op;
            if (wr)
                shadow_mem[key] = addr[4] ? wblk.half.hi : wblk.half.lo;
            else if (addr[4])
                cur.half.hi = shadow_mem[key];
            else
                cur.half.lo = shadow_mem[key];
            shadow_blk[p] = cur;
        end else if (en && !fresh && !rdy) begin
            $display("port %0d case %0s: repeated request was not answered at once", p, name);
            errors++;
        end
        if (en && rdy && !wr) begin
            compare_half(name, "hi", cur.half.hi, file_blk.half.hi, blk.half.hi);
            compare_half(name, "lo", cur.half.lo, file_blk.half.lo, blk.half.lo);
        end
    endtask

    always @(posedge ui_clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**`MEM_AW; i++)
                shadow_mem[i] = '0;
            for (int p = 0; p < 2; p++) begin
                shadow_blk[p] = '0;
                last_addr[p]  = '1;
                last_op[p]    = ddr_pkg::OP_NOP;
            end
            reset_checked = 1'b0;
            errors        = 0;
        end else begin
            if (!reset_checked) begin
                // idle ports right out of reset
                if (!p0_ram_rdy || !p1_ram_rdy) begin
                    $display("ram_rdy is not high on both ports after reset");
                    errors++;
                end
                compare_half("reset_p0", "full lo", '0, '0, p0_block_out.half.lo);
                compare_half("reset_p0", "full hi", '0, '0, p0_block_out.half.hi);
                compare_half("reset_p1", "full lo", '0, '0, p1_block_out.half.lo);
                compare_half("reset_p1", "full hi", '0, '0, p1_block_out.half.hi);
                reset_checked = 1'b1;
            end
            step_port(0, p0_ram_en, p0_ram_write, p0_ram_addr, p0_data_to_ram,
                p0_ram_rdy, p0_block_out, name0, exp0);
            step_port(1, p1_ram_en, p1_ram_write, p1_ram_addr, p1_data_to_ram,
                p1_ram_rdy, p1_block_out, name1, exp1);
        end
    end

endmodule

/* tb_ddr_subsys.sv */
// ddr front end testbench
`timescale 1ns/1ps
`include "ddr_cfg.svh"

module tb_ddr_subsys;

    localparam int MAXC = 64;   // case table depth
    localparam int TMO  = 200;  // cycles per ram_rdy wait

    logic                   ui_clk;
    logic                   rst;
    logic                   p0_ram_en, p0_ram_write, p1_ram_en, p1_ram_write;
    logic [`RAM_AW-1:0]     p0_ram_addr, p1_ram_addr;
    logic [2*`APP_DW-1:0]   p0_data_to_ram, p1_data_to_ram;
    logic                   p0_ram_rdy, p1_ram_rdy;
    ddr_pkg::block_t        p0_block_out, p1_block_out;
    logic [127:0]           name0, name1;
    logic [2*`APP_DW-1:0]   exp0, exp1;
    int                     chk_errors;
    int                     timeouts;
    int                     file_errors;
    int                     seed;

    // case table from ddr_cases.txt
    logic [127:0]           c_name [MAXC];
    int                     c_port [MAXC];
    logic [7:0]             c_op [MAXC];
    logic [`RAM_AW-1:0]     c_addr [MAXC];
    logic [2*`APP_DW-1:0]   c_data [MAXC];
    int                     n_cases;

    initial ui_clk = 1'b0;
    always #50 ui_clk = ~ui_clk;    // 100 ns period

    ddr_subsys_top uut (
        .ui_clk(ui_clk), .rst(rst),
        .p0_ram_en(p0_ram_en), .p0_ram_write(p0_ram_write), .p0_ram_addr(p0_ram_addr),
        .p0_data_to_ram(p0_data_to_ram), .p0_ram_rdy(p0_ram_rdy),
        .p0_block_out(p0_block_out),
        .p1_ram_en(p1_ram_en), .p1_ram_write(p1_ram_write), .p1_ram_addr(p1_ram_addr),
        .p1_data_to_ram(p1_data_to_ram), .p1_ram_rdy(p1_ram_rdy),
        .p1_block_out(p1_block_out)
    );

    tb_checker u_chk (
        .ui_clk(ui_clk), .rst(rst),
        .p0_ram_en(p0_ram_en), .p0_ram_write(p0_ram_write), .p0_ram_addr(p0_ram_addr),
        .p0_data_to_ram(p0_data_to_ram), .p0_ram_rdy(p0_ram_rdy),
        .p0_block_out(p0_block_out),
        .p1_ram_en(p1_ram_en), .p1_ram_write(p1_ram_write), .p1_ram_addr(p1_ram_addr),
        .p1_data_to_ram(p1_data_to_ram), .p1_ram_rdy(p1_ram_rdy),
        .p1_block_out(p1_block_out),
        .name0(name0), .name1(name1), .exp0(exp0), .exp1(exp1), .errors(chk_errors)
    );

    // --------------------
    // case file
    // --------------------
    task automatic load_cases();
        int                     fd;
        int                     code;
        int                     ch;
        logic                   stop;
        logic [127:0]           tok;
        int                     port;
        logic [7:0]             op;
        logic [`RAM_AW-1:0]     addr;
        logic [2*`APP_DW-1:0]   data;
        stop = 1'b0;
        fd   = $fopen("ddr_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open ddr_cases.txt for reading");
            file_errors++;
        end else begin
            while (!stop && !$feof(fd) && n_cases < MAXC) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    stop = 1'b1;                    // end of file
                end else if (tok == "#") begin
                    ch = $fgetc(fd);                // skip comment line
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end else begin
                    code = $fscanf(fd, "%d %s %h %h", port, op, addr, data);
                    if (code == 4) begin
                        c_name[n_cases] = tok;
                        c_port[n_cases] = port;
                        c_op[n_cases]   = op;
                        c_addr[n_cases] = addr;
                        c_data[n_cases] = data;
                        n_cases++;
                    end else begin
                        $display("malformed line in ddr_cases.txt after %0s", tok);
                        file_errors++;
                        stop = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // drivers, falling edge
    // --------------------
    task automatic drive_port(input int p, input int idx);
        logic en;
        en = (c_op[idx] != "X");    // X leaves the port idle
        if (p == 0) begin
            p0_ram_en      = en;
            p0_ram_write   = (c_op[idx] == "W");
            p0_ram_addr    = c_addr[idx];
            p0_data_to_ram = c_data[idx];
            name0          = c_name[idx];
            exp0           = c_data[idx];
        end else begin
            p1_ram_en      = en;
            p1_ram_write   = (c_op[idx] == "W");
            p1_ram_addr    = c_addr[idx];
            p1_data_to_ram = c_data[idx];
            name1          = c_name[idx];
            exp1           = c_data[idx];
        end
    endtask

    // hold requests until each used port shows ram_rdy
    task automatic wait_ready(input logic use0, input logic use1);
        logic got0;
        logic got1;
        int   cyc;
        got0 = !use0;
        got1 = !use1;
        cyc  = 0;
        while (!(got0 && got1) && cyc < TMO) begin
            @(posedge ui_clk);
            if (p0_ram_rdy)
                got0 = 1'b1;
            if (p1_ram_rdy)
                got1 = 1'b1;
            cyc++;
        end
        if (!got0) begin
            $display("port 0 case %0s got no ram_rdy within %0d cycles", name0, TMO);
            timeouts++;
        end
        if (!got1) begin
            $display("port 1 case %0s got no ram_rdy within %0d cycles", name1, TMO);
            timeouts++;
        end
    endtask

    task automatic run_cases();
        int   i;
        int   gap;
        logic pair;
        logic use0;
        logic use1;
        i = 0;
        while (i < n_cases) begin
            // same name on the next line, other port: launch together
            pair = (i + 1 < n_cases) && (c_name[i] == c_name[i+1])
                && (c_port[i] != c_port[i+1]);
            use0 = (c_port[i] == 0) || (pair && c_port[i+1] == 0);
            use1 = (c_port[i] == 1) || (pair && c_port[i+1] == 1);
            @(negedge ui_clk);
            drive_port(c_port[i], i);
            if (pair)
                drive_port(c_port[i+1], i + 1);
            wait_ready(use0, use1);
            @(posedge ui_clk);          // one more edge with the finished request held
            @(negedge ui_clk);
            p0_ram_en = 1'b0;
            p1_ram_en = 1'b0;
            gap = $random(seed) & 3;    // 0..3 extra idle cycles
            repeat (gap) @(negedge ui_clk);
            i = pair ? i + 2 : i + 1;
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst            = 1'b0;
        p0_ram_en      = 1'b0;
        p0_ram_write   = 1'b0;
        p0_ram_addr    = '0;
        p0_data_to_ram = '0;
        p1_ram_en      = 1'b0;
        p1_ram_write   = 1'b0;
        p1_ram_addr    = '0;
        p1_data_to_ram = '0;
        name0          = "none";
        name1          = "none";
        exp0           = '0;
        exp1           = '0;
        timeouts       = 0;
        file_errors    = 0;
        n_cases        = 0;
        seed           = 26417;
        load_cases();
        repeat (4) @(posedge ui_clk);   // reset held 4 cycles
        @(negedge ui_clk);
        rst = 1'b1;
        // first cases start well before calibration ends
        if (n_cases > 0)
            run_cases();
        else
            file_errors++;
        repeat (4) @(posedge ui_clk);
        $display("errors: checker %0d, timeouts %0d, case file %0d, cases run %0d",
            chk_errors, timeouts, file_errors, n_cases);
        if (chk_errors == 0 && timeouts == 0 && file_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
ddr_pkg.sv
ddr_port_ctrl.sv
app_arbiter.sv
app_mem_model.sv
ddr_subsys_top.sv
tb_checker.sv
tb_ddr_subsys.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_subsys \
		-f list.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* ddr_cases.txt */
# name port op(R read, W write, X idle) word_addr(hex) block(hex, hi half first)
# read lines carry the block_out expected after the read
pre_cal_wr  0 W 00000010 1111111111111111111111111111111122222222222222222222222222222222
pre_cal_wr  1 W 00000020 3333333333333333333333333333333344444444444444444444444444444444
rd_back_hi  0 R 00000010 1111111111111111111111111111111100000000000000000000000000000000
rd_back_lo  1 R 00000020 0000000000000000000000000000000044444444444444444444444444444444
wr_lo       0 W 00000000 5555555555555555555555555555555566666666666666666666666666666666
wr_rep      0 W 00000000 7777777777777777777777777777777788888888888888888888888888888888
rd_other    1 R 00000000 0000000000000000000000000000000066666666666666666666666666666666
rd_lo       0 R 00000000 1111111111111111111111111111111166666666666666666666666666666666
rd_rep      0 R 00000000 1111111111111111111111111111111166666666666666666666666666666666
idle_p0     0 X 00000000 0
both_wr     0 W 00000030 99999999999999999999999999999999aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
both_wr     1 W 00000040 bbbbbbbbbbbbbbbbbbbbbbbbbbbbbbbbcccccccccccccccccccccccccccccccc
both_rd     0 R 00000040 11111111111111111111111111111111cccccccccccccccccccccccccccccccc
both_rd     1 R 00000030 9999999999999999999999999999999966666666666666666666666666666666
both_rd2    0 R 00000010 11111111111111111111111111111111cccccccccccccccccccccccccccccccc
both_rd2    1 R 00000020 9999999999999999999999999999999944444444444444444444444444444444
mix_w1      1 W 000000f0 ddddddddddddddddddddddddddddddddeeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee
mix_w2      0 W 000000e5 ffffffffffffffffffffffffffffffff22222222222222222222222222222222
mix_r1      0 R 000000f0 ddddddddddddddddddddddddddddddddcccccccccccccccccccccccccccccccc
mix_r2      1 R 000000e5 9999999999999999999999999999999922222222222222222222222222222222
mix_w3      1 W 3ff000f0 3333333333333333333333333333333355555555555555555555555555555555
mix_r3      0 R 100000f0 33333333333333333333333333333333cccccccccccccccccccccccccccccccc
mix_w4      0 W 00000007 4444444444444444444444444444444477777777777777777777777777777777
mix_r4      1 R 00000007 9999999999999999999999999999999977777777777777777777777777777777
mix_r5      1 R 00000017 0000000000000000000000000000000077777777777777777777777777777777
mix_w5      1 W 00000017 88888888888888888888888888888888aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
mix_r6      0 R 00000017 88888888888888888888888888888888cccccccccccccccccccccccccccccccc
mix_r7      1 R 00000010 1111111111111111111111111111111177777777777777777777777777777777
mix_pair    0 R 000000e5 8888888888888888888888888888888822222222222222222222222222222222
mix_pair    1 R 00000030 9999999999999999999999999999999977777777777777777777777777777777
